/* build.f */
+incdir+bench
common/isa_pkg.sv
common/window_pkg.sv
window/operand_wakeup.sv
window/entry_store.sv
window/window_ctrl.sv
hw/issue_mux.sv
hw/iw_top.sv
bench/iw_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := iw_tb
FILELIST := build.f
OBJ      := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ) $(LOG)

/* bench/iw_model.svh */
`ifndef IW_MODEL_SVH
`define IW_MODEL_SVH

// window contents in age order with the oldest at index 0
dispatch_t model_q[$];

function automatic dispatch_t apply_wakeup(input dispatch_t d, input wakeup_t w);
    dispatch_t r;
    r = d;
    if (w.valid && !r.src1_ready && r.src1_tag == w.tag) begin
        r.src1_ready = 1'b1;
        r.src1_value = w.value;
    end
    if (w.valid && !r.src2_ready && r.src2_tag == w.tag) begin
        r.src2_ready = 1'b1;
        r.src2_value = w.value;
    end
    return r;
endfunction

function automatic logic flush_hits(input dispatch_t d, input flush_t f);
    return f.valid && ((d.ctx & f.mask) != '0);
endfunction

// loads and stores carry base plus immediate as operand_a
function automatic issue_t expected_packet(input dispatch_t d);
    issue_t p;
    p.opcode = d.opcode;
    p.operand_a = d.src1_value;
    if (d.opcode == load || d.opcode == store) begin
        p.operand_a = d.src1_value + d.imm;
    end
    p.operand_b = d.src2_value;
    p.dest_tag = d.dest_tag;
    p.ctx = d.ctx;
    return p;
endfunction

task automatic wake_all(input wakeup_t w);
    foreach (model_q[i]) begin
        model_q[i] = apply_wakeup(model_q[i], w);
    end
endtask

// -1 when nothing can go
function automatic int oldest_ready(input flush_t f);
    foreach (model_q[i]) begin
        if (model_q[i].src1_ready && model_q[i].src2_ready && !flush_hits(model_q[i], f)) begin
            return i;
        end
    end
    return -1;
endfunction

// state after the coming edge
task automatic advance_model(input int idx, input logic take, input flush_t f,
                             input logic ins, input dispatch_t d, input wakeup_t w);
    dispatch_t kept[$];
    foreach (model_q[i]) begin
        if (!(take && i == idx) && !flush_hits(model_q[i], f)) begin
            kept.push_back(model_q[i]);
        end
    end
    if (ins) begin
        kept.push_back(apply_wakeup(d, w));
    end
    model_q = kept;
endtask

`endif

/* bench/iw_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module iw_tb;
    import isa_pkg::*;
    import window_pkg::*;

    localparam int WINDOW_DEPTH = 8;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_CYCLES = 3000;
    localparam int HOLD_CYCLES = 40;
    localparam int FILL_CYCLES = 2 * WINDOW_DEPTH + 4;
    localparam int CYCLE_LIMIT = RESET_CYCLES + RANDOM_CYCLES + HOLD_CYCLES + FILL_CYCLES + 200;

    logic      clk = 1'b0;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    dispatch_t in_entry;
    logic      out_valid;
    logic      out_ready;
    issue_t    out_packet;
    wakeup_t   wakeup;
    flush_t    flush;

    integer seed = 45;
    int     cycles = 0;
    int     test_errors = 0;
    int     passed_tests = 0;
    int     failed_tests = 0;
    int     filled;
    logic   held_valid;
    issue_t held_packet;

    `include "iw_model.svh"

    iw_top #(.WINDOW_DEPTH(WINDOW_DEPTH)) iw_top_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_entry   (in_entry),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_packet (out_packet),
        .wakeup     (wakeup),
        .flush      (flush)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic dispatch_t make_entry(input logic all_ready);
        dispatch_t d;
        d.opcode = opcode_t'(3'(rand_below(6)));
        d.src1_tag = tag_t'($random(seed));
        d.src2_tag = tag_t'($random(seed));
        d.src1_ready = all_ready || rand_below(2) == 0;
        d.src2_ready = all_ready || rand_below(2) == 0;
        d.src1_value = d.src1_ready ? word_t'($random(seed)) : '0;
        d.src2_value = d.src2_ready ? word_t'($random(seed)) : '0;
        d.imm = word_t'($random(seed));
        d.dest_tag = tag_t'($random(seed));
        d.ctx = ctx_t'(4'b0001 << rand_below(4));
        return d;
    endfunction

    // broadcast a tag that something in flight is waiting on
    function automatic wakeup_t pick_wakeup();
        tag_t    waiting[$];
        wakeup_t w;
        w = '0;
        foreach (model_q[i]) begin
            if (!model_q[i].src1_ready) waiting.push_back(model_q[i].src1_tag);
            if (!model_q[i].src2_ready) waiting.push_back(model_q[i].src2_tag);
        end
        if (in_valid && !in_entry.src1_ready) waiting.push_back(in_entry.src1_tag);
        if (in_valid && !in_entry.src2_ready) waiting.push_back(in_entry.src2_tag);
        if (waiting.size() > 0 && rand_below(4) != 0) begin
            w.valid = 1'b1;
            w.tag = waiting[rand_below(waiting.size())];
            w.value = word_t'($random(seed));
        end
        return w;
    endfunction

    task automatic idle_inputs();
        in_valid = 1'b0;
        in_entry = '0;
        out_ready = 1'b0;
        wakeup = '0;
        flush = '0;
    endtask

    task automatic drive_random();
        in_valid = rand_below(4) != 0;
        in_entry = make_entry(1'b0);
        out_ready = rand_below(2) == 0;
        flush = '0;
        // flushes are rare
        if (rand_below(64) == 0) begin
            flush.valid = 1'b1;
            flush.mask = 4'b0001 << rand_below(4);
        end
        wakeup = pick_wakeup();
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // sample at the falling edge, then move the model past the next rising edge
    task automatic check_cycle();
        int     idx;
        logic   room;
        issue_t want;
        #4;
        room = model_q.size() < WINDOW_DEPTH;
        wake_all(wakeup);
        idx = oldest_ready(flush);
        assert (in_ready == room) else begin
            $display("error at %0t: in_ready is %0b with %0d entries held",
                     $time, in_ready, model_q.size());
            test_errors++;
        end
        assert (out_valid == (idx >= 0)) else begin
            $display("error at %0t: out_valid is %0b, expected %0b", $time, out_valid, idx >= 0);
            test_errors++;
        end
        if (out_valid && idx >= 0) begin
            want = expected_packet(model_q[idx]);
            assert (out_packet == want) else begin
                $display("error at %0t: out_packet %h, expected %h", $time, out_packet, want);
                test_errors++;
            end
        end
        if (out_valid && flush.valid) begin
            assert ((out_packet.ctx & flush.mask) == '0) else begin
                $display("error at %0t: packet of a flushed context offered", $time);
                test_errors++;
            end
        end
        advance_model(idx, out_ready && idx >= 0, flush, in_valid && room, in_entry, wakeup);
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
            passed_tests++;
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    initial begin
        reset = 1'b1;
        idle_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        #4;
        assert (!out_valid && in_ready) else begin
            $display("error at %0t: out_valid %0b in_ready %0b after reset",
                     $time, out_valid, in_ready);
            test_errors++;
        end
        end_test("reset");

        repeat (RANDOM_CYCLES) begin
            next_cycle();
            drive_random();
            check_cycle();
        end
        end_test("random_traffic");

        // under back-pressure with no wakeup or flush the offer must not move
        held_valid = 1'b0;
        repeat (HOLD_CYCLES) begin
            next_cycle();
            drive_random();
            out_ready = 1'b0;
            wakeup = '0;
            flush = '0;
            check_cycle();
            if (held_valid) begin
                assert (out_valid && out_packet == held_packet) else begin
                    $display("error at %0t: offered packet changed under back-pressure", $time);
                    test_errors++;
                end
            end
            held_valid = out_valid;
            held_packet = out_packet;
        end
        end_test("hold");

        // empty the window, fill it, then let one entry go
        next_cycle();
        idle_inputs();
        flush.valid = 1'b1;
        flush.mask = '1;
        check_cycle();
        filled = 0;
        next_cycle();
        while (in_ready && filled < FILL_CYCLES) begin
            idle_inputs();
            in_valid = 1'b1;
            in_entry = make_entry(1'b1);
            check_cycle();
            filled++;
            next_cycle();
        end
        assert (!in_ready) else begin
            $display("error at %0t: in_ready still high after %0d dispatches", $time, filled);
            test_errors++;
        end
        idle_inputs();
        out_ready = 1'b1;
        check_cycle();
        next_cycle();
        idle_inputs();
        assert (in_ready) else begin
            $display("error at %0t: in_ready still low after one issue", $time);
            test_errors++;
        end
        check_cycle();
        end_test("fill_and_drain");

        $display("tests: %0d passed, %0d failed", passed_tests, failed_tests);
        if (failed_tests == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/iw_top.sv */
`timescale 1ns/1ps
`default_nettype none

module iw_top #(
    parameter int WINDOW_DEPTH = 8
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 in_valid,
    output logic                in_ready,
    input  wire isa_pkg::dispatch_t in_entry,
    output logic                out_valid,
    input  wire                 out_ready,
    output isa_pkg::issue_t     out_packet,
    input  wire window_pkg::wakeup_t wakeup,
    input  wire window_pkg::flush_t  flush
);
    import window_pkg::*;

    localparam int IDX_W = $clog2(WINDOW_DEPTH);

    entry_t [WINDOW_DEPTH-1:0] stored_entries;
    entry_t [WINDOW_DEPTH-1:0] woken_entries;
    entry_t [0:0]              incoming;
    entry_t [0:0]              incoming_woken;
    logic [IDX_W-1:0]          issue_index;
    logic [WINDOW_DEPTH-1:0]   keep_mask;
    logic                      insert;

    if (WINDOW_DEPTH < 2) begin : g_depth_check
        $error("iw_top needs WINDOW_DEPTH of 2 or more");
    end

    assign incoming[0] = '{valid: in_valid, inst: in_entry};

    entry_store #(.WINDOW_DEPTH(WINDOW_DEPTH)) entry_store_inst (
        .clk        (clk),
        .reset      (reset),
        .entries_in (woken_entries),
        .keep_mask  (keep_mask),
        .insert     (insert),
        .new_entry  (incoming_woken[0].inst),
        .entries    (stored_entries)
    );

    // wakeup for the stored window
    operand_wakeup #(.ENTRIES(WINDOW_DEPTH)) window_wakeup_inst (
        .clk         (clk),
        .reset       (reset),
        .wakeup      (wakeup),
        .entries_in  (stored_entries),
        .entries_out (woken_entries)
    );

    // same broadcast also catches the instruction being dispatched
    operand_wakeup #(.ENTRIES(1)) dispatch_wakeup_inst (
        .clk         (clk),
        .reset       (reset),
        .wakeup      (wakeup),
        .entries_in  (incoming),
        .entries_out (incoming_woken)
    );

    window_ctrl #(.WINDOW_DEPTH(WINDOW_DEPTH)) window_ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .entries     (woken_entries),
        .flush       (flush),
        .in_valid    (in_valid),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .issue_index (issue_index),
        .keep_mask   (keep_mask),
        .in_ready    (in_ready),
        .insert      (insert)
    );

    issue_mux #(.WINDOW_DEPTH(WINDOW_DEPTH)) issue_mux_inst (
        .entries     (woken_entries),
        .issue_index (issue_index),
        .out_packet  (out_packet)
    );

endmodule

`default_nettype wire

/* hw/issue_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_mux #(
    parameter int WINDOW_DEPTH = 8
) (
    input  wire window_pkg::entry_t [WINDOW_DEPTH-1:0] entries,
    input  wire [$clog2(WINDOW_DEPTH)-1:0]             issue_index,
    output isa_pkg::issue_t                            out_packet
);
    import isa_pkg::*;

    dispatch_t sel;
    logic      is_mem;

    assign sel = entries[issue_index].inst;

    // memory ops get their address base formed here
    assign is_mem = (sel.opcode == load) || (sel.opcode == store);

    always_comb begin
        out_packet.opcode = sel.opcode;
        if (is_mem) begin
            out_packet.operand_a = sel.src1_value + sel.imm;
        end else begin
            out_packet.operand_a = sel.src1_value;
        end
        out_packet.operand_b = sel.src2_value;
        out_packet.dest_tag = sel.dest_tag;
        out_packet.ctx = sel.ctx;
    end

endmodule

`default_nettype wire

/* window/window_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module window_ctrl #(
    parameter int WINDOW_DEPTH = 8
) (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire window_pkg::entry_t [WINDOW_DEPTH-1:0] entries,
    input  wire window_pkg::flush_t                    flush,
    input  wire                                        in_valid,
    input  wire                                        out_ready,
    output logic                                       out_valid,
    output logic [$clog2(WINDOW_DEPTH)-1:0]            issue_index,
    output logic [WINDOW_DEPTH-1:0]                    keep_mask,
    output logic                                       in_ready,
    output logic                                       insert
);
    localparam int IDX_W = $clog2(WINDOW_DEPTH);
    localparam int CNT_W = $clog2(WINDOW_DEPTH + 1);

    logic [WINDOW_DEPTH-1:0] valid_mask;
    logic [WINDOW_DEPTH-1:0] flush_hit;
    logic [WINDOW_DEPTH-1:0] ready_mask;
    logic [WINDOW_DEPTH-1:0] sel_onehot;
    logic [CNT_W-1:0]        valid_count;

    always_comb begin
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            valid_mask[i] = entries[i].valid;
            flush_hit[i] = flush.valid && (|(flush.mask & entries[i].inst.ctx));
            // flushed entries are never offered
            ready_mask[i] = valid_mask[i] && entries[i].inst.src1_ready
                && entries[i].inst.src2_ready && !flush_hit[i];
        end
    end

    // slot 0 holds the oldest, so the lowest set bit wins
    assign sel_onehot = ready_mask & (~ready_mask + 1'b1);
    assign out_valid = |ready_mask;

    always_comb begin
        issue_index = '0;
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            if (sel_onehot[i]) begin
                issue_index = IDX_W'(i);
            end
        end
    end

    // drop the issued entry and anything on the flushed path
    assign keep_mask = valid_mask & ~flush_hit & ~(sel_onehot & {WINDOW_DEPTH{out_ready}});

    always_comb begin
        valid_count = '0;
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            valid_count = valid_count + CNT_W'(valid_mask[i]);
        end
    end

    // valid bits come straight from the registers
    assign in_ready = valid_count != CNT_W'(WINDOW_DEPTH);
    assign insert = in_valid && in_ready;

    a_issue_ready: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> entries[issue_index].valid
            && entries[issue_index].inst.src1_ready
            && entries[issue_index].inst.src2_ready);

    // storage packs toward slot 0, so room means the top slot is empty
    a_no_insert_full: assert property (@(posedge clk) disable iff (reset)
        insert |-> !entries[WINDOW_DEPTH-1].valid);

endmodule

`default_nettype wire

/* window/entry_store.sv */
`timescale 1ns/1ps
`default_nettype none

module entry_store #(
    parameter int WINDOW_DEPTH = 8
) (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire window_pkg::entry_t [WINDOW_DEPTH-1:0] entries_in,
    input  wire [WINDOW_DEPTH-1:0]                     keep_mask,
    input  wire                                        insert,
    input  wire isa_pkg::dispatch_t                    new_entry,
    output window_pkg::entry_t [WINDOW_DEPTH-1:0]      entries
);
    import window_pkg::*;

    localparam int CNT_W = $clog2(WINDOW_DEPTH + 1);

    entry_t [WINDOW_DEPTH-1:0] next_entries;

    // survivors keep their relative age order
    always_comb begin
        logic [CNT_W-1:0] fill;

        next_entries = '0;
        fill = '0;
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            if (keep_mask[i]) begin
                next_entries[fill] = entries_in[i];
                fill = fill + 1'b1;
            end
        end
        // youngest goes right behind the survivors
        if (insert) begin
            next_entries[fill].valid = 1'b1;
            next_entries[fill].inst = new_entry;
        end
    end

    always_ff @(posedge clk) begin
        entries <= next_entries;
        if (reset) begin
            for (int i = 0; i < WINDOW_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* window/operand_wakeup.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_wakeup #(
    parameter int ENTRIES = 1
) (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire window_pkg::wakeup_t              wakeup,
    input  wire window_pkg::entry_t [ENTRIES-1:0] entries_in,
    output window_pkg::entry_t [ENTRIES-1:0]      entries_out
);
    logic [ENTRIES-1:0] hit1;
    logic [ENTRIES-1:0] hit2;

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            // only sources still waiting look at the broadcast
            hit1[i] = wakeup.valid && entries_in[i].valid
                && !entries_in[i].inst.src1_ready
                && (entries_in[i].inst.src1_tag == wakeup.tag);
            hit2[i] = wakeup.valid && entries_in[i].valid
                && !entries_in[i].inst.src2_ready
                && (entries_in[i].inst.src2_tag == wakeup.tag);
            entries_out[i] = entries_in[i];
            if (hit1[i]) begin
                entries_out[i].inst.src1_ready = 1'b1;
                entries_out[i].inst.src1_value = wakeup.value;
            end
            if (hit2[i]) begin
                entries_out[i].inst.src2_ready = 1'b1;
                entries_out[i].inst.src2_value = wakeup.value;
            end
        end
    end

    for (genvar g = 0; g < ENTRIES; g++) begin : g_check
        a_src1_kept: assert property (@(posedge clk) disable iff (reset)
            entries_in[g].inst.src1_ready
                |-> entries_out[g].inst.src1_value == entries_in[g].inst.src1_value);
        a_src2_kept: assert property (@(posedge clk) disable iff (reset)
            entries_in[g].inst.src2_ready
                |-> entries_out[g].inst.src2_value == entries_in[g].inst.src2_value);
    end

endmodule

`default_nettype wire

/* common/window_pkg.sv */
`default_nettype none

package window_pkg;

    // follows the mask carried in the instruction
    localparam int CTX_W = $bits(isa_pkg::ctx_t);

    // one window slot
    typedef struct packed {
        logic              valid;
        isa_pkg::dispatch_t inst;
    } entry_t;

    // result broadcast once per cycle
    typedef struct packed {
        logic          valid;
        isa_pkg::tag_t tag;
        isa_pkg::word_t value;
    } wakeup_t;

    // branch flush kills every entry sharing a mask bit
    typedef struct packed {
        logic             valid;
        logic [CTX_W-1:0] mask;
    } flush_t;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int WORD_W = 32;
    localparam int TAG_W = 6;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;

    // branch context mask with one bit per live speculation level
    typedef logic [3:0] ctx_t;

    typedef enum logic [2:0] {
        add    = 3'd0,
        sub    = 3'd1,
        and_op = 3'd2,
        or_op  = 3'd3,
        load   = 3'd4,
        store  = 3'd5
    } opcode_t;

    // decoded instruction as handed over by dispatch
    typedef struct packed {
        opcode_t opcode;
        tag_t    src1_tag;
        tag_t    src2_tag;
        logic    src1_ready;
        logic    src2_ready;
        word_t   src1_value;
        word_t   src2_value;
        word_t   imm;
        tag_t    dest_tag;
        ctx_t    ctx;
    } dispatch_t;

    typedef struct packed {
        opcode_t opcode;
        word_t   operand_a;
        word_t   operand_b;
        tag_t    dest_tag;
        ctx_t    ctx;
    } issue_t;

endpackage

`default_nettype wire
